// ==== hw/rv_exec_defs.svh ====
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// Machine width and register file depth.
`define RV_XLEN 64
`define RV_NREGS 32

// Pipeline register pc after reset.
`define RV_RESET_PC 64'h7ffffffc

// Major opcodes, instruction bits [6:0].
`define RV_OP_IMM    7'b0010011
`define RV_OP        7'b0110011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_STORE  7'b0100011
`define RV_OP_SYSTEM 7'b1110011

// Store sizes as carried in mem_size.
`define RV_SIZE_B 2'd0
`define RV_SIZE_H 2'd1
`define RV_SIZE_W 2'd2
`define RV_SIZE_D 2'd3

`endif

// ==== hw/rv_exec_pkg.sv ====
package rv_exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Write-back source.
    typedef enum logic [1:0] {
        RES_ALU    = 2'd0,
        RES_IMM    = 2'd1, // LUI.
        RES_PC_IMM = 2'd2  // AUIPC.
    } res_sel_e;

    typedef struct packed {
        logic [6:0] funct7; // Also imm[11:5] for I-type.
        logic [4:0] rs2;    // Also imm[4:0] for I-type.
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_ri_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef union packed {
        inst_ri_t r;
        inst_s_t  s;
    } inst_u;

endpackage

// ==== hw/id_ex_if.sv ====
`include "rv_exec_defs.svh"

interface id_ex_if import rv_exec_pkg::*; ();

    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         inst;
    alu_op_e             alu_op;
    res_sel_e            res_sel;
    logic [`RV_XLEN-1:0] src1;
    logic [`RV_XLEN-1:0] src2;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs2_data; // Store data, after forwarding.
    logic                mem_en;
    logic                mem_wen;
    logic [1:0]          mem_size;
    logic                rf_we;
    logic [4:0]          rd;
    logic                sys;

    modport producer (
        output pc, inst, alu_op, res_sel, src1, src2, imm, rs2_data,
               mem_en, mem_wen, mem_size, rf_we, rd, sys
    );

    modport consumer (
        input pc, inst, alu_op, res_sel, src1, src2, imm, rs2_data,
              mem_en, mem_wen, mem_size, rf_we, rd, sys
    );

endinterface

// ==== hw/rv_decode.sv ====
`include "rv_exec_defs.svh"

module rv_decode import rv_exec_pkg::*; (
    input  logic                inst_valid,
    input  logic [`RV_XLEN-1:0] pc,
    input  inst_u               inst,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic                fwd_we,
    input  logic [4:0]          fwd_rd,
    input  logic [`RV_XLEN-1:0] fwd_data,
    id_ex_if.producer           id
);

    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_u;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] op1, op2;
    logic                use_imm;
    logic                rf_we, mem_en, sys;
    alu_op_e             alu_op;
    res_sel_e            res_sel;

    assign imm_i = {{52{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2};
    assign imm_s = {{52{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_u = {{32{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2, inst.r.rs1,
                    inst.r.funct3, 12'b0};

    always_comb begin
        alu_op  = ALU_ADD;
        res_sel = RES_ALU;
        imm     = '0;
        use_imm = 1'b0;
        rf_we   = 1'b0;
        mem_en  = 1'b0;
        sys     = 1'b0;
        case (inst.r.opcode)
            `RV_OP_IMM, `RV_OP: begin
                use_imm = (inst.r.opcode == `RV_OP_IMM);
                imm     = imm_i;
                rf_we   = 1'b1;
                case (inst.r.funct3)
                    3'b000: alu_op = (!use_imm && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL; // imm[10] for SRAI.
                    3'b110: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            `RV_OP_LUI: begin
                imm     = imm_u;
                use_imm = 1'b1;
                res_sel = RES_IMM;
                rf_we   = 1'b1;
            end
            `RV_OP_AUIPC: begin
                imm     = imm_u;
                use_imm = 1'b1;
                res_sel = RES_PC_IMM;
                rf_we   = 1'b1;
            end
            `RV_OP_STORE: begin
                imm     = imm_s;
                use_imm = 1'b1;
                mem_en  = 1'b1;
            end
            `RV_OP_SYSTEM: sys = (inst.r.funct3 == 3'b000) && (imm_i == '0); // ECALL only.
            default: ;
        endcase
        if (!inst_valid) begin // Bubble.
            rf_we  = 1'b0;
            mem_en = 1'b0;
            sys    = 1'b0;
        end
    end

    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    // EX result bypass; x0 never forwards.
    assign op1 = (fwd_we && fwd_rd != 5'd0 && fwd_rd == rs1_addr) ? fwd_data : rs1_data;
    assign op2 = (fwd_we && fwd_rd != 5'd0 && fwd_rd == rs2_addr) ? fwd_data : rs2_data;

    assign id.pc       = pc;
    assign id.inst     = inst;
    assign id.alu_op   = alu_op;
    assign id.res_sel  = res_sel;
    assign id.src1     = op1;
    assign id.src2     = use_imm ? imm : op2;
    assign id.imm      = imm;
    assign id.rs2_data = op2;
    assign id.mem_en   = mem_en;
    assign id.mem_wen  = mem_en; // Stores are the only memory ops.
    assign id.mem_size = inst.s.funct3[1:0];
    assign id.rf_we    = rf_we;
    assign id.rd       = inst.r.rd;
    assign id.sys      = sys;

endmodule

// ==== hw/rv_regfile.sv ====
`include "rv_exec_defs.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data,
    input  logic                we,
    input  logic [4:0]          rd,
    input  logic [`RV_XLEN-1:0] wdata
);

    // x0 has no storage.
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/rv_id_ex_reg.sv ====
`include "rv_exec_defs.svh"

module rv_id_ex_reg import rv_exec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      ena,
    id_ex_if.consumer id,
    id_ex_if.producer ex
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.pc       <= `RV_RESET_PC;
            ex.inst     <= '0;
            ex.alu_op   <= ALU_ADD;
            ex.res_sel  <= RES_ALU;
            ex.src1     <= '0;
            ex.src2     <= '0;
            ex.imm      <= '0;
            ex.rs2_data <= '0;
            ex.mem_en   <= 1'b0;
            ex.mem_wen  <= 1'b0;
            ex.mem_size <= '0;
            ex.rf_we    <= 1'b0;
            ex.rd       <= '0;
            ex.sys      <= 1'b0;
        end else if (ena) begin // Holds while stalled.
            ex.pc       <= id.pc;
            ex.inst     <= id.inst;
            ex.alu_op   <= id.alu_op;
            ex.res_sel  <= id.res_sel;
            ex.src1     <= id.src1;
            ex.src2     <= id.src2;
            ex.imm      <= id.imm;
            ex.rs2_data <= id.rs2_data;
            ex.mem_en   <= id.mem_en;
            ex.mem_wen  <= id.mem_wen;
            ex.mem_size <= id.mem_size;
            ex.rf_we    <= id.rf_we;
            ex.rd       <= id.rd;
            ex.sys      <= id.sys;
        end
    end

endmodule

// ==== hw/rv_alu.sv ====
`include "rv_exec_defs.svh"

module rv_alu import rv_exec_pkg::*; (
    id_ex_if.consumer           ex,
    output logic                res_we,
    output logic [4:0]          res_rd,
    output logic [`RV_XLEN-1:0] res_data,
    output logic                mem_en,
    output logic                mem_wen,
    output logic [7:0]          mem_mask,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output logic                sys
);

    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] alu_res;
    logic [5:0]          shamt;
    logic [7:0]          size_mask;

    assign sum   = ex.src1 + ex.src2;
    assign shamt = ex.src2[5:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:  alu_res = sum;
            ALU_SUB:  alu_res = ex.src1 - ex.src2;
            ALU_SLL:  alu_res = ex.src1 << shamt;
            ALU_SLT:  alu_res = {63'b0, $signed(ex.src1) < $signed(ex.src2)};
            ALU_SLTU: alu_res = {63'b0, ex.src1 < ex.src2};
            ALU_XOR:  alu_res = ex.src1 ^ ex.src2;
            ALU_SRL:  alu_res = ex.src1 >> shamt;
            ALU_SRA:  alu_res = $signed(ex.src1) >>> shamt;
            ALU_OR:   alu_res = ex.src1 | ex.src2;
            ALU_AND:  alu_res = ex.src1 & ex.src2;
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (ex.res_sel)
            RES_IMM:    res_data = ex.imm;
            RES_PC_IMM: res_data = ex.pc + ex.imm;
            default:    res_data = alu_res;
        endcase
    end

    // Byte lanes covered by the access size, before alignment.
    always_comb begin
        case (ex.mem_size)
            `RV_SIZE_B: begin
                size_mask = 8'h01;
                mem_wdata = {8{ex.rs2_data[7:0]}};
            end
            `RV_SIZE_H: begin
                size_mask = 8'h03;
                mem_wdata = {4{ex.rs2_data[15:0]}};
            end
            `RV_SIZE_W: begin
                size_mask = 8'h0f;
                mem_wdata = {2{ex.rs2_data[31:0]}};
            end
            default: begin
                size_mask = 8'hff;
                mem_wdata = ex.rs2_data;
            end
        endcase
    end

    assign mem_mask = ex.mem_en ? (size_mask << sum[2:0]) : 8'h00;
    assign mem_addr = sum;
    assign mem_en   = ex.mem_en;
    assign mem_wen  = ex.mem_wen;
    assign res_we   = ex.rf_we;
    assign res_rd   = ex.rd;
    assign sys      = ex.sys;

endmodule

// ==== hw/rv_exec_core.sv ====
`include "rv_exec_defs.svh"

module rv_exec_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                inst_valid,
    input  logic                stall,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [31:0]         inst,
    output logic [`RV_XLEN-1:0] ex_pc,
    output logic                res_we,
    output logic [4:0]          res_rd,
    output logic [`RV_XLEN-1:0] res_data,
    output logic                mem_en,
    output logic                mem_wen,
    output logic [7:0]          mem_mask,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_wdata,
    output logic                sys
);

    logic [4:0]          rs1_addr, rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data, rs2_data;

    id_ex_if id ();
    id_ex_if ex ();

    rv_decode u_decode (
        .inst_valid(inst_valid), .pc(pc), .inst(inst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .fwd_we(res_we), .fwd_rd(res_rd), .fwd_data(res_data), // EX result bypass.
        .id(id)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(res_we), .rd(res_rd), .wdata(res_data)
    );

    rv_id_ex_reg u_id_ex_reg (.clk(clk), .rst(rst), .ena(!stall), .id(id), .ex(ex));

    rv_alu u_alu (
        .ex(ex), .res_we(res_we), .res_rd(res_rd), .res_data(res_data),
        .mem_en(mem_en), .mem_wen(mem_wen), .mem_mask(mem_mask),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .sys(sys)
    );

    assign ex_pc = ex.pc;

endmodule

// ==== test/rv_exec_chk.sv ====
module rv_exec_chk (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic [63:0] ex_pc,
    input logic        res_we,
    input logic [4:0]  res_rd,
    input logic [63:0] res_data,
    input logic        mem_en,
    input logic [7:0]  mem_mask,
    input logic [63:0] mem_addr,
    input logic [63:0] mem_wdata,
    input logic        sys
);

    int fail_cnt = 0;

    a_reset_quiet: assert property (@(posedge clk) rst |=> !res_we && !mem_en && !sys)
        else begin
            $error("outputs active after reset");
            fail_cnt++;
        end

    // A stalled edge leaves the EX stage unchanged.
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(res_data) && $stable(res_we) && $stable(res_rd) && $stable(mem_en)
                  && $stable(mem_mask) && $stable(mem_addr) && $stable(mem_wdata)
                  && $stable(sys) && $stable(ex_pc))
        else begin
            $error("outputs changed during stall");
            fail_cnt++;
        end

    a_store_no_wb: assert property (@(posedge clk) disable iff (rst) !(mem_en && res_we))
        else begin
            $error("store with register write");
            fail_cnt++;
        end

endmodule

bind rv_exec_core rv_exec_chk u_chk (.*);

// ==== test/tb_rv_exec_core.sv ====
`include "rv_exec_defs.svh"

module tb_rv_exec_core import rv_exec_pkg::*; ();

    typedef struct {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        mem_en;
        logic [7:0]  mask;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic        sys;
        logic [63:0] pc;
    } exp_t;

    localparam int N_TOTAL = 125 + 36 + 33 + 61 + 5;
    localparam int LIMIT = N_TOTAL * 4 + 100;

    logic clk = 1'b0;
    logic rst, inst_valid, stall;
    logic [63:0] pc;
    logic [31:0] inst;
    logic [63:0] ex_pc, res_data, mem_addr, mem_wdata;
    logic [4:0] res_rd;
    logic [7:0] mem_mask;
    logic res_we, mem_en, mem_wen, sys;

    logic [63:0] shadow [0:31];
    exp_t exp_q[$];
    logic [63:0] cur_pc;
    int seed = 1;
    int errors = 0;
    int test_errs;
    int cycles = 0;
    logic [63:0] last_data, last_addr, last_wdata, last_pc;
    logic [7:0] last_mask;
    logic [2:0] last_flags;

    rv_exec_core u_rv_exec_core (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        inst_u u;
        u.r.funct7 = f7;
        u.r.rs2    = rs2;
        u.r.rs1    = rs1;
        u.r.funct3 = f3;
        u.r.rd     = rd;
        u.r.opcode = op;
        return u;
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [1:0] size);
        inst_u u;
        u.s.imm_hi = imm[11:5];
        u.s.rs2    = rs2;
        u.s.rs1    = rs1;
        u.s.funct3 = {1'b0, size};
        u.s.imm_lo = imm[4:0];
        u.s.opcode = `RV_OP_STORE;
        return u;
    endfunction

    // Expected outputs from the RV64I rules and the shadow register file.
    function automatic exp_t predict(input logic [31:0] w, input logic [63:0] p);
        exp_t e;
        logic [63:0] a, b, y, immi, imms, immu;
        logic [7:0] sm;
        e = '{default: 0};
        e.valid = 1'b1;
        e.pc = p;
        e.rd = w[11:7];
        a = shadow[w[19:15]];
        b = shadow[w[24:20]];
        immi = {{52{w[31]}}, w[31:20]};
        imms = {{52{w[31]}}, w[31:25], w[11:7]};
        immu = {{32{w[31]}}, w[31:12], 12'b0};
        case (w[6:0])
            `RV_OP, `RV_OP_IMM: begin
                y = (w[6:0] == `RV_OP) ? b : immi;
                e.we = 1'b1;
                case (w[14:12])
                    3'd0: e.data = (w[6:0] == `RV_OP && w[30]) ? a - y : a + y;
                    3'd1: e.data = a << y[5:0];
                    3'd2: e.data = {63'b0, $signed(a) < $signed(y)};
                    3'd3: e.data = {63'b0, a < y};
                    3'd4: e.data = a ^ y;
                    3'd5: begin
                        if (w[30])
                            e.data = $signed(a) >>> y[5:0];
                        else
                            e.data = a >> y[5:0];
                    end
                    3'd6: e.data = a | y;
                    default: e.data = a & y;
                endcase
            end
            `RV_OP_LUI: begin
                e.we = 1'b1;
                e.data = immu;
            end
            `RV_OP_AUIPC: begin
                e.we = 1'b1;
                e.data = p + immu;
            end
            `RV_OP_STORE: begin
                e.mem_en = 1'b1;
                e.addr = a + imms;
                case (w[13:12])
                    2'd0: sm = 8'h01;
                    2'd1: sm = 8'h03;
                    2'd2: sm = 8'h0f;
                    default: sm = 8'hff;
                endcase
                for (int i = 0; i < 8; i++) // Low store bytes repeat across the lanes.
                    e.wdata[i*8 +: 8] = b[(i % (1 << w[13:12])) * 8 +: 8];
                e.mask = sm << e.addr[2:0];
            end
            `RV_OP_SYSTEM: e.sys = (w[14:12] == 3'd0) && (w[31:20] == 12'd0);
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        logic [2:0] f3;
        logic alt;
        int kind;
        f3 = $random(seed);
        alt = $random(seed);
        kind = {$random(seed)} % 8;
        if (kind < 4)
            return enc_r((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, alt, 5'b0} : 7'b0,
                         rs2, rs1, f3, rd, `RV_OP);
        if (kind < 7) begin
            if (f3 == 3'd1 || f3 == 3'd5) // Shift amount in imm[5:0].
                return enc_r({1'b0, alt && f3 == 3'd5, 4'b0, rs2[0]}, $random(seed), rs1, f3,
                             rd, `RV_OP_IMM);
            return enc_r($random(seed), $random(seed), rs1, f3, rd, `RV_OP_IMM);
        end
        return enc_r($random(seed), $random(seed), $random(seed), $random(seed), rd,
                     alt ? `RV_OP_LUI : `RV_OP_AUIPC);
    endfunction

    task automatic issue(input logic [31:0] w, input logic v);
        exp_t e;
        @(negedge clk);
        inst = w;
        pc = cur_pc;
        inst_valid = v;
        stall = 1'b0;
        if (v) begin
            e = predict(w, cur_pc);
            if (e.we && e.rd != 5'd0)
                shadow[e.rd] = e.data;
        end else begin
            e = '{default: 0};
        end
        exp_q.push_back(e);
        cur_pc += 4;
    endtask

    task automatic hold(input int n);
        repeat (n) begin
            @(negedge clk);
            stall = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        issue(32'h0, 1'b0);
        while (exp_q.size() != 0)
            @(posedge clk);
        #2;
        $display("%s: done, %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    // Compare one cycle after issue; stalled edges must leave the outputs unchanged.
    always @(posedge clk) begin
        exp_t e;
        logic cap, held;
        cap = !rst && !stall;
        held = !rst && stall;
        #1;
        if (cap && exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check("res_we", res_we, e.we);
            check("mem_en", mem_en, e.mem_en);
            check("sys", sys, e.sys);
            check("mem_mask", mem_mask, e.mask);
            if (e.valid)
                check("ex_pc", ex_pc, e.pc);
            if (e.we) begin
                check("res_rd", res_rd, e.rd);
                check("res_data", res_data, e.data);
            end
            if (e.mem_en) begin
                check("mem_wen", mem_wen, 1'b1);
                check("mem_addr", mem_addr, e.addr);
                check("mem_wdata", mem_wdata, e.wdata);
            end
        end else if (held) begin
            check("res_data", res_data, last_data);
            check("mem_addr", mem_addr, last_addr);
            check("mem_wdata", mem_wdata, last_wdata);
            check("ex_pc", ex_pc, last_pc);
            check("mem_mask", mem_mask, last_mask);
            check("res_we/mem_en/sys", {res_we, mem_en, sys}, last_flags);
        end
        last_data = res_data;
        last_addr = mem_addr;
        last_wdata = mem_wdata;
        last_pc = ex_pc;
        last_mask = mem_mask;
        last_flags = {res_we, mem_en, sys};
    end

    initial begin
        logic [4:0] r;
        rst = 1'b1;
        inst_valid = 1'b0;
        stall = 1'b0;
        pc = '0;
        inst = '0;
        cur_pc = 64'h1000;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_errs = 0;
        check("ex_pc", ex_pc, `RV_RESET_PC);
        check("res_we/mem_en/sys", {res_we, mem_en, sys}, 3'b000);
        $display("reset: done, %0d errors", errors);
        test_errs = errors;

        for (int i = 1; i < 32; i++) begin // Fill every register with a random value.
            issue(enc_r($random(seed), $random(seed), $random(seed), $random(seed), i,
                        `RV_OP_LUI), 1'b1);
            issue(enc_r($random(seed), $random(seed), i, 3'd0, i, `RV_OP_IMM), 1'b1);
        end
        issue(enc_r(7'h40, 5'd0, 5'd0, 3'd0, 5'd5, `RV_OP_LUI), 1'b1); // Negative x5.
        issue(enc_r(7'h20, 5'd3, 5'd5, 3'd5, 5'd6, `RV_OP), 1'b1);
        issue(enc_r(7'h20, 5'd7, 5'd5, 3'd5, 5'd7, `RV_OP_IMM), 1'b1);
        for (int i = 0; i < 59; i++)
            issue(rand_alu($random(seed), $random(seed), $random(seed)), 1'b1);
        end_test("alu random");

        r = 5'd9;
        for (int i = 0; i < 32; i++)
            issue(rand_alu(r, r, r), 1'b1);
        issue(enc_r(7'h0, 5'd5, 5'd1, 3'd0, 5'd0, `RV_OP_IMM), 1'b1); // Write to x0.
        issue(enc_r(7'h0, 5'd0, 5'd0, 3'd0, 5'd2, `RV_OP), 1'b1);
        issue(enc_r(7'h0, 5'd0, 5'd0, 3'd6, 5'd3, `RV_OP), 1'b1);
        end_test("dependent chain");

        for (int i = 0; i < 32; i++)
            issue(enc_s($random(seed), $random(seed), $random(seed), $random(seed)), 1'b1);
        end_test("stores");

        for (int i = 0; i < 60; i++) begin
            if ({$random(seed)} % 3 == 0)
                hold(1 + {$random(seed)} % 2);
            if ({$random(seed)} % 4 == 0)
                issue($random(seed), 1'b0);
            else if ({$random(seed)} % 3 == 0)
                issue(enc_s($random(seed), $random(seed), $random(seed), $random(seed)), 1'b1);
            else
                issue(rand_alu($random(seed), $random(seed), $random(seed)), 1'b1);
        end
        end_test("stall and bubbles");

        issue(enc_r(7'h0, 5'd0, 5'd0, 3'd0, 5'd0, `RV_OP_SYSTEM), 1'b1);
        issue(rand_alu(5'd4, 5'd4, 5'd1), 1'b1);
        issue(enc_r(7'h0, 5'd0, 5'd0, 3'd0, 5'd0, `RV_OP_SYSTEM), 1'b1);
        issue(rand_alu(5'd4, 5'd4, 5'd2), 1'b1);
        end_test("ecall");

        errors += u_rv_exec_core.u_chk.fail_cnt; // Bound assertion failures.
        $display("Summary: %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_exec_core.f ====
+incdir+hw
hw/rv_exec_pkg.sv
hw/id_ex_if.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_id_ex_reg.sv
hw/rv_alu.sv
hw/rv_exec_core.sv
test/rv_exec_chk.sv
test/tb_rv_exec_core.sv

// ==== Bender.yml ====
package:
  name: rv_exec_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_exec_pkg.sv
      - hw/id_ex_if.sv
      - hw/rv_decode.sv
      - hw/rv_regfile.sv
      - hw/rv_id_ex_reg.sv
      - hw/rv_alu.sv
      - hw/rv_exec_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/rv_exec_chk.sv
      - test/tb_rv_exec_core.sv
